/* verilog/cache_pkg.sv */
package cache_pkg;

    // geometry
    localparam int word_width     = 32;
    localparam int words_per_line = 4;
    localparam int num_lines      = 8;

    // address split of a 30-bit word address
    localparam int word_sel_width = 2;
    localparam int index_width    = 3;
    localparam int tag_width      = 25;

    typedef logic [word_width-1:0]                word_t;
    typedef logic [tag_width-1:0]                 tag_t;
    typedef logic [index_width-1:0]               index_t;
    typedef logic [word_sel_width-1:0]            word_sel_t;
    // word 0 sits in the low bits
    typedef logic [words_per_line*word_width-1:0] line_t;

    typedef struct packed {
        tag_t      tag;
        index_t    index;
        word_sel_t word_sel;
    } cache_addr_t;

    typedef struct packed {
        logic        read;
        logic        write;
        cache_addr_t addr;
        word_t       wdata;
    } proc_req_t;

    typedef enum logic [1:0] {
        st_compare,
        st_write_back,
        st_allocate
    } ctrl_state_t;

    typedef enum logic [1:0] {
        upd_none,
        upd_word,
        upd_fill
    } update_op_t;

    // one store update per cycle
    typedef struct packed {
        update_op_t op;
        index_t     index;
        word_sel_t  word_sel;
        tag_t       tag;
        word_t      word;
        line_t      line;
    } line_update_t;

endpackage

/* verilog/mem_bus_pkg.sv */
package mem_bus_pkg;

    // memory is addressed by whole lines
    localparam int mem_addr_width = 28;
    localparam int mem_data_width = 128;

    typedef logic [mem_addr_width-1:0] mem_addr_t;

    // held until ready is seen
    typedef struct packed {
        logic                      read;
        logic                      write;
        mem_addr_t                 addr;
        logic [mem_data_width-1:0] wdata;
    } mem_req_t;

    // ready is a one-cycle strobe, rdata valid with it
    typedef struct packed {
        logic                      ready;
        logic [mem_data_width-1:0] rdata;
    } mem_resp_t;

endpackage

/* verilog/cache_line_store.sv */
`timescale 1ns/1ps

module cache_line_store
    import cache_pkg::*;
(
    input  logic         clk,
    input  logic         proc_reset,
    input  index_t       lookup_index,
    input  line_update_t update,
    output line_t        rd_line,
    output tag_t         rd_tag,
    output logic         rd_valid,
    output logic         rd_dirty
);

    line_t                data_mem [num_lines];
    tag_t                 tag_mem  [num_lines];
    logic [num_lines-1:0] valid_bits;
    logic [num_lines-1:0] dirty_bits;

    // combinational read of the indexed line
    assign rd_line  = data_mem[lookup_index];
    assign rd_tag   = tag_mem[lookup_index];
    assign rd_valid = valid_bits[lookup_index];
    assign rd_dirty = dirty_bits[lookup_index];

    // data and tag arrays
    always_ff @(posedge clk) begin
        case (update.op)
            upd_word: begin
                data_mem[update.index][update.word_sel * word_width +: word_width]
                    <= update.word;
            end
            upd_fill: begin
                data_mem[update.index] <= update.line;
                tag_mem[update.index]  <= update.tag;
            end
            default: begin
            end
        endcase
    end

    // line status
    always_ff @(posedge clk or posedge proc_reset) begin
        if (proc_reset) begin
            valid_bits <= '0;
            dirty_bits <= '0;
        end else begin
            case (update.op)
                upd_word: begin
                    dirty_bits[update.index] <= 1'b1;
                end
                upd_fill: begin
                    valid_bits[update.index] <= 1'b1;
                    dirty_bits[update.index] <= 1'b0;
                end
                default: begin
                end
            endcase
        end
    end

    // a word write only lands in a valid line holding the same tag
    a_word_update_hits: assert property (
        @(posedge clk) disable iff (proc_reset)
        (update.op == upd_word) |->
            (valid_bits[update.index] && (tag_mem[update.index] == update.tag))
    );

endmodule

/* verilog/cache_controller.sv */
`timescale 1ns/1ps

module cache_controller
    import cache_pkg::*;
    import mem_bus_pkg::*;
(
    input  logic         clk,
    input  logic         proc_reset,
    input  proc_req_t    proc_req,
    input  line_t        rd_line,
    input  tag_t         rd_tag,
    input  logic         rd_valid,
    input  logic         rd_dirty,
    input  mem_resp_t    mem_resp,
    output logic         proc_stall,
    output word_t        proc_rdata,
    output line_update_t update,
    output mem_req_t     mem_req
);

    ctrl_state_t state;
    ctrl_state_t state_next;
    mem_req_t    mem_req_next;
    logic        access;
    logic        hit;
    mem_addr_t   req_line_addr;
    mem_addr_t   victim_line_addr;

    assign access = proc_req.read || proc_req.write;

    // tag compare on the indexed line
    assign hit = rd_valid && (rd_tag == proc_req.addr.tag);

    // a hit in st_compare finishes in the same cycle
    assign proc_stall = (state != st_compare) || (access && !hit);

    assign proc_rdata = rd_line[proc_req.addr.word_sel * word_width +: word_width];

    assign req_line_addr    = {proc_req.addr.tag, proc_req.addr.index};
    assign victim_line_addr = {rd_tag, proc_req.addr.index};

    always_comb begin
        state_next   = state;
        mem_req_next = mem_req;

        // payload always follows the held request
        update.op       = upd_none;
        update.index    = proc_req.addr.index;
        update.word_sel = proc_req.addr.word_sel;
        update.tag      = proc_req.addr.tag;
        update.word     = proc_req.wdata;
        update.line     = mem_resp.rdata;

        case (state)
            st_compare: begin
                if (access && hit) begin
                    if (proc_req.write) begin
                        update.op = upd_word;
                    end
                end else if (access && rd_valid && rd_dirty) begin
                    // victim goes out first
                    state_next         = st_write_back;
                    mem_req_next.write = 1'b1;
                    mem_req_next.addr  = victim_line_addr;
                    mem_req_next.wdata = rd_line;
                end else if (access) begin
                    state_next        = st_allocate;
                    mem_req_next.read = 1'b1;
                    mem_req_next.addr = req_line_addr;
                end
            end

            st_write_back: begin
                if (mem_resp.ready) begin
                    state_next         = st_allocate;
                    mem_req_next.write = 1'b0;
                    mem_req_next.read  = 1'b1;
                    mem_req_next.addr  = req_line_addr;
                end
            end

            st_allocate: begin
                if (mem_resp.ready) begin
                    // refill, the access hits next cycle
                    state_next        = st_compare;
                    mem_req_next.read = 1'b0;
                    update.op         = upd_fill;
                end
            end

            default: begin
                state_next   = st_compare;
                mem_req_next = '0;
            end
        endcase
    end

    always_ff @(posedge clk or posedge proc_reset) begin
        if (proc_reset) begin
            state   <= st_compare;
            mem_req <= '0;
        end else begin
            state   <= state_next;
            mem_req <= mem_req_next;
        end
    end

    a_mem_rw_exclusive: assert property (
        @(posedge clk) disable iff (proc_reset)
        !(mem_req.read && mem_req.write)
    );

    // request held until memory answers
    a_mem_req_stable: assert property (
        @(posedge clk) disable iff (proc_reset)
        (mem_req.read || mem_req.write) && !mem_resp.ready |=> $stable(mem_req)
    );

endmodule

/* verilog/cache.sv */
`timescale 1ns/1ps

module cache
    import cache_pkg::*;
    import mem_bus_pkg::*;
(
    input  logic                         clk,
    input  logic                         proc_reset,
    input  logic                         proc_read,
    input  logic                         proc_write,
    input  logic [$bits(cache_addr_t)-1:0] proc_addr,
    input  word_t                        proc_wdata,
    output logic                         proc_stall,
    output word_t                        proc_rdata,
    output logic                         mem_read,
    output logic                         mem_write,
    output mem_addr_t                    mem_addr,
    output line_t                        mem_wdata,
    input  logic                         mem_ready,
    input  line_t                        mem_rdata
);

    proc_req_t    proc_req;
    mem_req_t     mem_req;
    mem_resp_t    mem_resp;
    line_update_t update;
    line_t        rd_line;
    tag_t         rd_tag;
    logic         rd_valid;
    logic         rd_dirty;

    assign proc_req = '{
        read:  proc_read,
        write: proc_write,
        addr:  proc_addr,
        wdata: proc_wdata
    };

    assign mem_resp = '{ready: mem_ready, rdata: mem_rdata};

    assign mem_read  = mem_req.read;
    assign mem_write = mem_req.write;
    assign mem_addr  = mem_req.addr;
    assign mem_wdata = mem_req.wdata;

    cache_controller i_controller (
        .clk        (clk),
        .proc_reset (proc_reset),
        .proc_req   (proc_req),
        .rd_line    (rd_line),
        .rd_tag     (rd_tag),
        .rd_valid   (rd_valid),
        .rd_dirty   (rd_dirty),
        .mem_resp   (mem_resp),
        .proc_stall (proc_stall),
        .proc_rdata (proc_rdata),
        .update     (update),
        .mem_req    (mem_req)
    );

    // lookup follows the live request
    cache_line_store i_line_store (
        .clk          (clk),
        .proc_reset   (proc_reset),
        .lookup_index (proc_req.addr.index),
        .update       (update),
        .rd_line      (rd_line),
        .rd_tag       (rd_tag),
        .rd_valid     (rd_valid),
        .rd_dirty     (rd_dirty)
    );

endmodule

/* test/tb_mem_model.sv */
`timescale 1ns/1ps

module tb_mem_model
    import cache_pkg::*;
    import mem_bus_pkg::*;
(
    input  logic      clk,
    input  logic      proc_reset,
    input  logic      mem_read,
    input  logic      mem_write,
    input  mem_addr_t mem_addr,
    input  line_t     mem_wdata,
    output logic      mem_ready,
    output line_t     mem_rdata,
    output int        error_count
);

    line_t     store [mem_addr_t];
    int        wait_cnt;
    logic      req_read;
    logic      req_write;
    mem_addr_t req_addr;
    line_t     req_wdata;

    // lines never written hold word address xor 32'h5a5a0000
    function automatic line_t initial_line(input mem_addr_t addr);
        line_t line;
        for (int i = 0; i < words_per_line; i++) begin
            line[i*word_width +: word_width] = {2'b00, addr, i[1:0]} ^ 32'h5a5a0000;
        end
        return line;
    endfunction

    initial begin
        mem_ready   = 1'b0;
        mem_rdata   = '0;
        error_count = 0;
        wait_cnt    = 0;
        forever begin
            @(posedge clk);
            #0.5;
            // ready is a one-cycle strobe
            mem_ready = 1'b0;
            if (proc_reset) begin
                wait_cnt = 0;
            end else if (wait_cnt > 0) begin
                assert (mem_read === req_read && mem_write === req_write &&
                        mem_addr === req_addr && mem_wdata === req_wdata)
                else begin
                    error_count++;
                    $display("FAIL %0t: memory request changed before ready", $time);
                end
                wait_cnt--;
                if (wait_cnt == 0) begin
                    if (req_write) begin
                        store[req_addr] = req_wdata;
                    end else begin
                        mem_rdata = store.exists(req_addr) ? store[req_addr]
                                                           : initial_line(req_addr);
                    end
                    mem_ready = 1'b1;
                end
            end else if (mem_read || mem_write) begin
                req_read  = mem_read;
                req_write = mem_write;
                req_addr  = mem_addr;
                req_wdata = mem_wdata;
                wait_cnt  = $urandom_range(1, 4);
            end
        end
    end

endmodule

/* test/tb_cache.sv */
`timescale 1ns/1ps

module tb_cache
    import cache_pkg::*;
    import mem_bus_pkg::*;
();

    localparam int num_accesses   = 2000;
    localparam int timeout_cycles = num_accesses * 40;
    localparam int reset_cycles   = 10;

    logic        clk;
    logic        proc_reset;
    logic        proc_read;
    logic        proc_write;
    cache_addr_t proc_addr;
    word_t       proc_wdata;
    logic        proc_stall;
    word_t       proc_rdata;
    logic        mem_read;
    logic        mem_write;
    mem_addr_t   mem_addr;
    line_t       mem_wdata;
    logic        mem_ready;
    line_t       mem_rdata;
    int          mem_errors;

    int          errors;
    logic        prev_mem_write;
    // expected word per word address, and lines written since their fill
    word_t       ref_mem [logic [29:0]];
    bit          line_written [mem_addr_t];

    always #2 clk = ~clk;

    cache i_cache (
        .clk        (clk),
        .proc_reset (proc_reset),
        .proc_read  (proc_read),
        .proc_write (proc_write),
        .proc_addr  (proc_addr),
        .proc_wdata (proc_wdata),
        .proc_stall (proc_stall),
        .proc_rdata (proc_rdata),
        .mem_read   (mem_read),
        .mem_write  (mem_write),
        .mem_addr   (mem_addr),
        .mem_wdata  (mem_wdata),
        .mem_ready  (mem_ready),
        .mem_rdata  (mem_rdata)
    );

    tb_mem_model i_mem (
        .clk         (clk),
        .proc_reset  (proc_reset),
        .mem_read    (mem_read),
        .mem_write   (mem_write),
        .mem_addr    (mem_addr),
        .mem_wdata   (mem_wdata),
        .mem_ready   (mem_ready),
        .mem_rdata   (mem_rdata),
        .error_count (mem_errors)
    );

    function automatic word_t expected_word(input logic [29:0] addr);
        if (ref_mem.exists(addr)) begin
            return ref_mem[addr];
        end
        return {2'b00, addr} ^ 32'h5a5a0000;
    endfunction

    // four tags per index keep conflicts frequent
    function automatic cache_addr_t random_addr();
        cache_addr_t a;
        a.tag      = tag_t'($urandom_range(0, 3));
        a.index    = index_t'($urandom_range(0, num_lines - 1));
        a.word_sel = word_sel_t'($urandom_range(0, words_per_line - 1));
        return a;
    endfunction

    task automatic check_write_back();
        mem_addr_t line_addr;
        word_t     expected;
        line_addr = mem_addr;
        assert (line_written.exists(line_addr) && line_written[line_addr])
        else begin
            errors++;
            $display("line %h written back at %0t with no write since its fill",
                     line_addr, $time);
        end
        for (int i = 0; i < words_per_line; i++) begin
            expected = expected_word({line_addr, i[1:0]});
            assert (mem_wdata[i*word_width +: word_width] === expected)
            else begin
                errors++;
                $display("FAIL %0t: write-back line %h word %0d is %h, expected %h", $time,
                         line_addr, i, mem_wdata[i*word_width +: word_width], expected);
            end
        end
        line_written[line_addr] = 1'b0;
    endtask

    task automatic run_access(input logic is_write, input cache_addr_t addr,
                              input word_t wdata, input bit expect_hit);
        bit    first;
        bit    done;
        word_t expected;
        first      = 1'b1;
        done       = 1'b0;
        proc_read  = !is_write;
        proc_write = is_write;
        proc_addr  = addr;
        proc_wdata = wdata;
        while (!done) begin
            @(negedge clk);
            if (first && expect_hit) begin
                assert (!proc_stall && !mem_read && !mem_write)
                else begin
                    errors++;
                    $display("repeat access to line %h stalled or went to memory at %0t",
                             {addr.tag, addr.index}, $time);
                end
            end
            first = 1'b0;
            if (!proc_stall) begin
                done = 1'b1;
                if (!is_write) begin
                    expected = expected_word(addr);
                    assert (proc_rdata === expected)
                    else begin
                        errors++;
                        $display("FAIL %0t: read of %h returned %h, expected %h",
                                 $time, addr, proc_rdata, expected);
                    end
                end
            end
            @(posedge clk);
            #0.5;
        end
        // the access completed at the last edge
        if (is_write) begin
            ref_mem[addr]                      = wdata;
            line_written[{addr.tag, addr.index}] = 1'b1;
        end
    endtask

    always @(negedge clk) begin
        if (proc_reset) begin
            prev_mem_write = 1'b0;
        end else begin
            assert (!(mem_read && mem_write))
            else begin
                errors++;
                $display("mem_read and mem_write both high at %0t", $time);
            end
            if (mem_write && !prev_mem_write) begin
                check_write_back();
            end
            prev_mem_write = mem_write;
        end
    end

    initial begin
        repeat (timeout_cycles) @(posedge clk);
        $display("timeout after %0d cycles, traffic did not finish", timeout_cycles);
        $display("TESTS FAILED");
        $finish;
    end

    initial begin
        cache_addr_t addr;
        cache_addr_t last_addr;
        bit          have_last;
        bit          same_line;
        void'($urandom(32'h3b7));
        clk            = 1'b0;
        proc_reset     = 1'b1;
        proc_read      = 1'b0;
        proc_write     = 1'b0;
        proc_addr      = '0;
        proc_wdata     = '0;
        errors         = 0;
        prev_mem_write = 1'b0;
        have_last      = 1'b0;
        last_addr      = '0;
        repeat (reset_cycles) @(posedge clk);
        #0.5;
        proc_reset = 1'b0;
        @(negedge clk);
        assert (!proc_stall && !mem_read && !mem_write)
        else begin
            errors++;
            $display("stall or memory request active right after reset");
        end
        @(posedge clk);
        #0.5;
        for (int n = 0; n < num_accesses; n++) begin
            same_line = have_last && ($urandom_range(0, 3) == 0);
            addr      = random_addr();
            if (same_line) begin
                addr.tag   = last_addr.tag;
                addr.index = last_addr.index;
            end
            run_access(logic'($urandom_range(0, 1)), addr, $urandom(), same_line);
            last_addr = addr;
            have_last = 1'b1;
        end
        proc_read  = 1'b0;
        proc_write = 1'b0;
        repeat (2) @(posedge clk);
        $display("errors: %0d cache checks, %0d memory checks", errors, mem_errors);
        if (errors == 0 && mem_errors == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

/* verilog.f */
verilog/cache_pkg.sv
verilog/mem_bus_pkg.sv
verilog/cache_line_store.sv
verilog/cache_controller.sv
verilog/cache.sv
test/tb_mem_model.sv
test/tb_cache.sv

/* Makefile */
VERILATOR  ?= verilator
TOP        := tb_cache
FILELIST   := verilog.f
FLAGS      := --binary --timing --assert -j 0
LINT_FLAGS := --lint-only --timing -Wall
OBJ_DIR    := obj_dir
LOG        := sim.log

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: build
	./$(OBJ_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "TESTS FAILED" $(LOG); then exit 1; fi
	@if ! grep -q "TESTS PASSED" $(LOG); then echo "simulation ended early"; exit 1; fi

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
